// ==== verilog/audio_pkg.sv ====
package audio_pkg;

    // ==================================================
    // Sample and frame widths
    // ==================================================
    localparam int SAMPLE_W = 16;
    // Left word in the upper half, right word in the lower half
    localparam int FRAME_W  = 2 * SAMPLE_W;

    // FX volume field in the status word
    localparam int FXLVL_W   = 2;
    localparam int FXLVL_LSB = 6;

    // FX level codes, in menu order
    localparam logic [FXLVL_W-1:0] FX_HIGH      = 2'd0;
    localparam logic [FXLVL_W-1:0] FX_VERY_HIGH = 2'd1;
    localparam logic [FXLVL_W-1:0] FX_VERY_LOW  = 2'd2;
    localparam logic [FXLVL_W-1:0] FX_LOW       = 2'd3;

    // ==================================================
    // Defaults for the top level
    // ==================================================
    localparam int DEF_FIFO_DEPTH = 8;
    // Sample clock cycles per half bit clock
    localparam int DEF_BCLK_DIV   = 2;

    // Dropped sample counter
    localparam int DROP_W = 8;

endpackage

// ==== verilog/snd_capture.sv ====
`timescale 1ns/1ps

module snd_capture #(
    parameter int SIGNED_SND = 1,
    parameter int STEREO     = 1,
    parameter int FIFO_DEPTH = audio_pkg::DEF_FIFO_DEPTH
) (
    input  logic                           sample,
    input  logic                           reset_i,
    input  logic [audio_pkg::SAMPLE_W-1:0] snd_left_i,
    input  logic [audio_pkg::SAMPLE_W-1:0] snd_right_i,
    input  logic                           snd_stb_i,
    input  logic [31:0]                    status_i,
    input  logic                           credit_i,
    output logic                           push_o,
    output logic [audio_pkg::FRAME_W-1:0]  frame_o,
    output logic [audio_pkg::DROP_W-1:0]   drop_count_o
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    // Unsigned game sound gets its MSB flipped
    localparam logic [audio_pkg::SAMPLE_W-1:0] SIGN_MASK =
        (SIGNED_SND != 0) ? '0 : {1'b1, {(audio_pkg::SAMPLE_W-1){1'b0}}};

    logic [audio_pkg::SAMPLE_W-1:0] right_raw;
    logic [audio_pkg::SAMPLE_W-1:0] left_sgn;
    logic [audio_pkg::SAMPLE_W-1:0] right_sgn;
    logic [audio_pkg::FXLVL_W-1:0]  fx_level;
    logic [1:0]                     fx_shift;
    logic [audio_pkg::SAMPLE_W-1:0] left_vol;
    logic [audio_pkg::SAMPLE_W-1:0] right_vol;
    logic [CW-1:0]                  credits;
    logic                           take;

    // Mono games feed the left channel only
    assign right_raw = (STEREO != 0) ? snd_right_i : snd_left_i;

    assign left_sgn  = snd_left_i ^ SIGN_MASK;
    assign right_sgn = right_raw ^ SIGN_MASK;

    assign fx_level = status_i[audio_pkg::FXLVL_LSB +: audio_pkg::FXLVL_W];

    // Menu order is not loudness order
    always_comb begin
        case (fx_level)
            audio_pkg::FX_HIGH:      fx_shift = 2'd1;
            audio_pkg::FX_VERY_HIGH: fx_shift = 2'd0;
            audio_pkg::FX_VERY_LOW:  fx_shift = 2'd3;
            audio_pkg::FX_LOW:       fx_shift = 2'd2;
            default:                 fx_shift = 2'd1;
        endcase
    end

    assign left_vol  = $signed(left_sgn) >>> fx_shift;
    assign right_vol = $signed(right_sgn) >>> fx_shift;

    // A strobe is only accepted with a credit in hand
    assign take = snd_stb_i && (credits != '0);

    // ==================================================
    // Credits, push strobe and drop counter
    // ==================================================
    always_ff @(posedge sample) begin
        if (reset_i) begin
            push_o       <= 1'b0;
            credits      <= CW'(FIFO_DEPTH);
            drop_count_o <= '0;
        end else begin
            push_o  <= take;
            credits <= credits - CW'(take) + CW'(credit_i);
            // Saturates at all ones
            if (snd_stb_i && !take && (drop_count_o != '1)) begin
                drop_count_o <= drop_count_o + 1'b1;
            end
        end
    end

    always_ff @(posedge sample) begin
        if (take) begin
            frame_o <= {left_vol, right_vol};
        end
    end

endmodule

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
    parameter int FIFO_DEPTH = audio_pkg::DEF_FIFO_DEPTH
) (
    input  logic                          sample,
    input  logic                          reset_i,
    input  logic                          push_i,
    input  logic [audio_pkg::FRAME_W-1:0] frame_i,
    input  logic                          pop_i,
    output logic                          avail_o,
    output logic [audio_pkg::FRAME_W-1:0] head_o,
    output logic                          credit_o
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [audio_pkg::FRAME_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]                 wr_ptr;
    logic [AW-1:0]                 rd_ptr;
    logic [CW-1:0]                 count;
    logic                          do_pop;

    // Wraps for any depth, not just powers of two
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign avail_o = (count != '0);
    assign head_o  = mem[rd_ptr];
    assign do_pop  = pop_i && avail_o;

    // Storage is written without a full check
    always_ff @(posedge sample) begin
        if (push_i) begin
            mem[wr_ptr] <= frame_i;
        end
    end

    always_ff @(posedge sample) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CW'(push_i) - CW'(do_pop);
            // One credit back to capture per entry freed
            credit_o <= do_pop;
        end
    end

endmodule

// ==== verilog/i2s_serializer.sv ====
`timescale 1ns/1ps

module i2s_serializer #(
    parameter int BCLK_DIV = audio_pkg::DEF_BCLK_DIV
) (
    input  logic                          sample,
    input  logic                          reset_i,
    input  logic                          avail_i,
    input  logic [audio_pkg::FRAME_W-1:0] head_i,
    output logic                          pop_o,
    output logic                          i2s_bclk_o,
    output logic                          i2s_lrclk_o,
    output logic                          i2s_data_o
);

    localparam int DW = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
    localparam int BW = $clog2(audio_pkg::FRAME_W);

    logic [DW-1:0]                 div_cnt;
    logic                          half_tick;
    logic                          bclk_fall;
    logic [BW-1:0]                 bit_cnt;
    logic [BW-1:0]                 bit_next;
    logic                          frame_start;
    logic [audio_pkg::FRAME_W-1:0] shift_q;

    // ==================================================
    // Bit clock divider
    // ==================================================
    assign half_tick = (div_cnt == DW'(BCLK_DIV - 1));
    assign bclk_fall = half_tick && i2s_bclk_o;

    always_ff @(posedge sample) begin
        if (reset_i) begin
            div_cnt    <= '0;
            i2s_bclk_o <= 1'b0;
        end else if (half_tick) begin
            div_cnt    <= '0;
            i2s_bclk_o <= ~i2s_bclk_o;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==================================================
    // Frame sequencing and shifter
    // ==================================================
    assign bit_next = bit_cnt + 1'b1;

    // Last bit period of the frame ends here, and word select goes low
    assign frame_start = bclk_fall && (bit_cnt == BW'(audio_pkg::FRAME_W - 1));

    // The buffer pops on the same edge that loads the shifter
    assign pop_o = frame_start && avail_i;

    always_ff @(posedge sample) begin
        if (reset_i) begin
            // Start on the last slot so the first falling edge loads a frame
            bit_cnt     <= '1;
            i2s_lrclk_o <= 1'b0;
            i2s_data_o  <= 1'b0;
            shift_q     <= '0;
        end else if (bclk_fall) begin
            bit_cnt     <= bit_next;
            // Low for left half, high for right half
            i2s_lrclk_o <= bit_next[BW-1];
            // Data lags word select by one bit period,
            // so the old LSB goes out as the new word starts
            i2s_data_o  <= shift_q[audio_pkg::FRAME_W-1];
            if (frame_start) begin
                // Underrun sends silence
                shift_q <= avail_i ? head_i : '0;
            end else begin
                shift_q <= shift_q << 1;
            end
        end
    end

endmodule

// ==== verilog/i2s_audio_top.sv ====
`timescale 1ns/1ps

module i2s_audio_top #(
    parameter int SIGNED_SND = 1,
    parameter int STEREO     = 1,
    parameter int FIFO_DEPTH = audio_pkg::DEF_FIFO_DEPTH,
    parameter int BCLK_DIV   = audio_pkg::DEF_BCLK_DIV
) (
    input  logic                           sample,
    input  logic                           reset_i,
    input  logic [audio_pkg::SAMPLE_W-1:0] snd_left_i,
    input  logic [audio_pkg::SAMPLE_W-1:0] snd_right_i,
    input  logic                           snd_stb_i,
    input  logic [31:0]                    status_i,
    output logic                           i2s_bclk_o,
    output logic                           i2s_lrclk_o,
    output logic                           i2s_data_o,
    output logic [audio_pkg::DROP_W-1:0]   drop_count_o
);

    // Capture to buffer
    logic                          push;
    logic [audio_pkg::FRAME_W-1:0] frame;
    logic                          credit;

    // Buffer to serializer
    logic                          avail;
    logic [audio_pkg::FRAME_W-1:0] head;
    logic                          pop;

    // ==================================================
    // Pipeline stages
    // ==================================================
    snd_capture #(
        .SIGNED_SND   ( SIGNED_SND   ),
        .STEREO       ( STEREO       ),
        .FIFO_DEPTH   ( FIFO_DEPTH   )
    ) u_capture (
        .sample       ( sample       ),
        .reset_i      ( reset_i      ),
        .snd_left_i   ( snd_left_i   ),
        .snd_right_i  ( snd_right_i  ),
        .snd_stb_i    ( snd_stb_i    ),
        .status_i     ( status_i     ),
        .credit_i     ( credit       ),
        .push_o       ( push         ),
        .frame_o      ( frame        ),
        .drop_count_o ( drop_count_o )
    );

    sample_fifo #(
        .FIFO_DEPTH   ( FIFO_DEPTH   )
    ) u_fifo (
        .sample       ( sample       ),
        .reset_i      ( reset_i      ),
        .push_i       ( push         ),
        .frame_i      ( frame        ),
        .pop_i        ( pop          ),
        .avail_o      ( avail        ),
        .head_o       ( head         ),
        .credit_o     ( credit       )
    );

    i2s_serializer #(
        .BCLK_DIV     ( BCLK_DIV     )
    ) u_i2s (
        .sample       ( sample       ),
        .reset_i      ( reset_i      ),
        .avail_i      ( avail        ),
        .head_i       ( head         ),
        .pop_o        ( pop          ),
        .i2s_bclk_o   ( i2s_bclk_o   ),
        .i2s_lrclk_o  ( i2s_lrclk_o  ),
        .i2s_data_o   ( i2s_data_o   )
    );

endmodule

// ==== testbench/tb_i2s_audio_top.sv ====
`timescale 1ns/1ps

module tb_i2s_audio_top;

    localparam int FIFO_DEPTH  = audio_pkg::DEF_FIFO_DEPTH;
    localparam int BCLK_DIV    = audio_pkg::DEF_BCLK_DIV;
    localparam int NUM_REC     = 24;
    localparam int BURST_LEN   = FIFO_DEPTH + 6;
    localparam int NUM_SINGLE  = FIFO_DEPTH + 2;
    localparam int GAP_CYCLES  = 200;
    localparam int WAIT_LIMIT  = 4000;
    localparam logic [31:0] STATUS_BASE = 32'h5a00_0025;

    logic        sample = 1'b0;
    logic        reset_i;
    logic [15:0] snd_left_i;
    logic [15:0] snd_right_i;
    logic        snd_stb_i;
    logic [31:0] status_i;
    logic        i2s_bclk_o;
    logic        i2s_lrclk_o;
    logic        i2s_data_o;
    logic [7:0]  drop_count_o;

    logic [15:0] golden [NUM_REC*5];
    logic [31:0] exp_q [$];
    logic [31:0] rx_word;
    logic [31:0] lcg_state;
    logic        bclk_prev;
    logic        lr_prev;
    int          bclk_hold;
    int          zero_run;
    int          matched;
    int          checks;
    int          value_errors;
    int          other_errors;
    int          k;

    i2s_audio_top #(
        .SIGNED_SND   ( 1            ),
        .STEREO       ( 1            ),
        .FIFO_DEPTH   ( FIFO_DEPTH   ),
        .BCLK_DIV     ( BCLK_DIV     )
    ) dut0 (
        .sample       ( sample       ),
        .reset_i      ( reset_i      ),
        .snd_left_i   ( snd_left_i   ),
        .snd_right_i  ( snd_right_i  ),
        .snd_stb_i    ( snd_stb_i    ),
        .status_i     ( status_i     ),
        .i2s_bclk_o   ( i2s_bclk_o   ),
        .i2s_lrclk_o  ( i2s_lrclk_o  ),
        .i2s_data_o   ( i2s_data_o   ),
        .drop_count_o ( drop_count_o )
    );

    always #50 sample = ~sample;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // FX menu order maps to shifts 1, 0, 3, 2
    function automatic logic [15:0] scale_sample(input logic [15:0] raw, input logic [1:0] fx);
        int sh;
        case (fx)
            audio_pkg::FX_HIGH:      sh = 1;
            audio_pkg::FX_VERY_HIGH: sh = 0;
            audio_pkg::FX_VERY_LOW:  sh = 3;
            default:                 sh = 2;
        endcase
        return 16'($signed(raw) >>> sh);
    endfunction

    // ==================================================
    // I2S decoder
    // ==================================================
    task automatic take_frame(input logic [31:0] word);
        if (word === '0) begin
            zero_run++;
        end else begin
            zero_run = 0;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("Frame %h decoded while no sample was pending", word);
            end else begin
                check_value("i2s_data_o", word, exp_q.pop_front());
                matched++;
            end
        end
    endtask

    always @(negedge sample) begin
        if (reset_i) begin
            bclk_prev = 1'b0;
            lr_prev   = 1'b0;
            rx_word   = '0;
            bclk_hold = 0;
        end else begin
            // Bit clock toggles every BCLK_DIV sample cycles
            if (i2s_bclk_o != bclk_prev) begin
                check_value("i2s_bclk_o half period", 32'(bclk_hold), 32'(BCLK_DIV));
                bclk_hold = 1;
            end else begin
                bclk_hold++;
            end
            if (i2s_bclk_o && !bclk_prev) begin
                rx_word = {rx_word[30:0], i2s_data_o};
                // Word select fell, so this bit was the right LSB
                if (!i2s_lrclk_o && lr_prev) begin
                    take_frame(rx_word);
                end
                lr_prev = i2s_lrclk_o;
            end
            bclk_prev = i2s_bclk_o;
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    task automatic drive_strobe(input logic [15:0] left, input logic [15:0] right,
                                input logic [1:0] fx);
        @(posedge sample);
        snd_left_i  <= left;
        snd_right_i <= right;
        status_i    <= STATUS_BASE | (32'(fx) << audio_pkg::FXLVL_LSB);
        snd_stb_i   <= 1'b1;
    endtask

    task automatic end_strobe();
        @(posedge sample);
        snd_stb_i <= 1'b0;
    endtask

    task automatic wait_expected_empty(input string phase);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge sample);
            n++;
        end
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Timeout in %s: %0d frames never came out", phase, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic wait_zero_frames(input int count, input string phase);
        int n;
        n = 0;
        while (zero_run < count && n < WAIT_LIMIT) begin
            @(posedge sample);
            n++;
        end
        if (zero_run < count) begin
            other_errors++;
            $display("Timeout in %s: output never settled to silent frames", phase);
        end
    endtask

    task automatic wait_word_select_fall();
        int  n;
        logic prev;
        n = 0;
        prev = i2s_lrclk_o;
        @(negedge sample);
        while (!(prev && !i2s_lrclk_o) && n < WAIT_LIMIT) begin
            prev = i2s_lrclk_o;
            @(negedge sample);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            other_errors++;
            $display("Timeout waiting for word select to fall");
        end
    endtask

    task automatic check_reset_outputs();
        @(negedge sample);
        check_value("i2s_bclk_o", 32'(i2s_bclk_o), 32'h0);
        check_value("i2s_lrclk_o", 32'(i2s_lrclk_o), 32'h0);
        check_value("i2s_data_o", 32'(i2s_data_o), 32'h0);
    endtask

    task automatic check_drops(input int expected);
        @(negedge sample);
        check_value("drop_count_o", 32'(drop_count_o), 32'(expected));
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        reset_i     = 1'b1;
        snd_left_i  = '0;
        snd_right_i = '0;
        snd_stb_i   = 1'b0;
        status_i    = STATUS_BASE;
        lcg_state   = 32'hc798d5d0;
        $readmemh("testbench/audio_golden.dat", golden);
        for (int i = 0; i < NUM_REC * 5; i++) begin
            if ($isunknown(golden[i])) begin
                other_errors++;
                $display("Golden file is missing or short at word %0d", i);
                break;
            end
        end
        repeat (16) @(posedge sample);
        reset_i <= 1'b0;
        // Outputs idle right after reset
        check_reset_outputs();

        // Silence until the first strobe
        wait_zero_frames(3, "reset");
        check_drops(0);

        // Golden records at all four FX levels
        for (int r = 0; r < NUM_REC; r++) begin
            exp_q.push_back({golden[r*5+3], golden[r*5+4]});
            drive_strobe(golden[r*5], golden[r*5+1], golden[r*5+2][1:0]);
            end_strobe();
            repeat (GAP_CYCLES - 2) @(posedge sample);
        end
        wait_expected_empty("golden records");
        check_drops(0);

        // Back-to-back burst right after a frame start
        wait_word_select_fall();
        matched = 0;
        for (int i = 0; i < BURST_LEN; i++) begin
            logic [15:0] left;
            logic [15:0] right;
            lcg_state = lcg_next(lcg_state);
            left = lcg_state[31:16];
            lcg_state = lcg_next(lcg_state);
            right = lcg_state[31:16];
            exp_q.push_back({scale_sample(left, audio_pkg::FX_HIGH),
                             scale_sample(right, audio_pkg::FX_HIGH)});
            drive_strobe(left, right, audio_pkg::FX_HIGH);
        end
        end_strobe();
        zero_run = 0;
        wait_zero_frames(2, "burst drain");
        k = matched;
        if (k < FIFO_DEPTH) begin
            other_errors++;
            $display("Only %0d burst samples came out, fewer than the buffer depth", k);
        end
        check_drops(BURST_LEN - k);
        exp_q.delete();

        // Credits all returned, so single samples pass again
        for (int i = 0; i < NUM_SINGLE; i++) begin
            logic [15:0] left;
            logic [15:0] right;
            lcg_state = lcg_next(lcg_state);
            left = lcg_state[31:16];
            right = lcg_state[15:0];
            exp_q.push_back({scale_sample(left, 2'(i)), scale_sample(right, 2'(i))});
            drive_strobe(left, right, 2'(i));
            end_strobe();
            repeat (GAP_CYCLES - 2) @(posedge sample);
        end
        wait_expected_empty("single samples");
        check_drops(BURST_LEN - k);

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== i2s_audio_top.f ====
verilog/audio_pkg.sv
verilog/snd_capture.sv
verilog/sample_fifo.sv
verilog/i2s_serializer.sv
verilog/i2s_audio_top.sv
testbench/tb_i2s_audio_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_i2s_audio_top
FILELIST  = i2s_audio_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
DATA      = testbench/audio_golden.dat
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(DATA)
	./$(SIM) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/audio_golden.dat ====
// Columns: left_in right_in fx_level expected_left expected_right (hex)
// FX level shift: 0 -> 1 bit, 1 -> none, 2 -> 3 bits, 3 -> 2 bits
4000 C000 0 2000 E000
1234 8000 0 091A C000
7FF0 F010 0 3FF8 F808
0100 FF00 0 0080 FF80
A5A0 5A50 0 D2D0 2D28
8008 0008 0 C004 0004
4000 C000 1 4000 C000
1234 8000 1 1234 8000
7FF0 F010 1 7FF0 F010
0100 FF00 1 0100 FF00
A5A0 5A50 1 A5A0 5A50
8008 0008 1 8008 0008
4000 C000 2 0800 F800
1234 8000 2 0246 F000
7FF0 F010 2 0FFE FE02
0100 FF00 2 0020 FFE0
A5A0 5A50 2 F4B4 0B4A
8008 0008 2 F001 0001
4000 C000 3 1000 F000
1234 8000 3 048D E000
7FF0 F010 3 1FFC FC04
0100 FF00 3 0040 FFC0
A5A0 5A50 3 E968 1694
8008 0008 3 E002 0002
